//--- Makefile
SRCS := $(wildcard design/*.sv design/*.svh verification/*.sv)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
obj_dir/Vsoc_ctrl_tb: vlog.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module soc_ctrl_tb -f vlog.f

# exit status of the simulator is the test verdict
run: obj_dir/Vsoc_ctrl_tb
	./obj_dir/Vsoc_ctrl_tb

clean:
	rm -rf obj_dir

//--- design/cluster_ctrl_regs.sv
/* Cluster control registers */

`default_nettype none

`include "soc_ctrl_defines.svh"

module cluster_ctrl_regs
(
   input  logic                              HCLK,
   input  logic                              HRESETn,
   input  soc_ctrl_sig_pkg::reg_wr_t         wr_i,
   input  soc_ctrl_sig_pkg::reg_rd_t         rd_i,
   output soc_ctrl_sig_pkg::cluster_ctrl_t   cluster_ctrl_o,
   output logic                              cluster_irq_o,
   output logic [2*`SOC_DATA_W-1:0]          cluster_boot_addr_o,
   output logic [`SOC_DATA_W-1:0]            rdata_o
);

   always_ff @(posedge HCLK or negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         cluster_ctrl_o.byp      <= 1'b1; // cluster bypassed
         cluster_ctrl_o.pow      <= 1'b0;
         cluster_ctrl_o.fetch_en <= 1'b0;
         cluster_ctrl_o.rstn     <= 1'b1;
         cluster_irq_o           <= 1'b0;
         cluster_boot_addr_o     <= '0;
      end
      else if (wr_i.we)
      begin
         case (wr_i.reg_id)
            soc_ctrl_reg_pkg::REG_CLUSTER_CTRL:
               cluster_ctrl_o <= soc_ctrl_sig_pkg::cluster_ctrl_t'(wr_i.wdata[3:0]);
            soc_ctrl_reg_pkg::REG_CLUSTER_IRQ:
               cluster_irq_o <= wr_i.wdata[0];
            soc_ctrl_reg_pkg::REG_CLUSTER_BOOT0:
               cluster_boot_addr_o[`SOC_DATA_W-1:0] <= wr_i.wdata; // low word
            soc_ctrl_reg_pkg::REG_CLUSTER_BOOT1:
               cluster_boot_addr_o[2*`SOC_DATA_W-1:`SOC_DATA_W] <= wr_i.wdata;
            default:
               cluster_irq_o <= cluster_irq_o;
         endcase
      end
   end

   always_comb
   begin
      case (rd_i.reg_id)
         soc_ctrl_reg_pkg::REG_CLUSTER_CTRL:
            rdata_o = {28'h0, cluster_ctrl_o};
         soc_ctrl_reg_pkg::REG_CLUSTER_IRQ:
            rdata_o = {31'h0, cluster_irq_o};
         soc_ctrl_reg_pkg::REG_CLUSTER_BOOT0:
            rdata_o = cluster_boot_addr_o[`SOC_DATA_W-1:0];
         soc_ctrl_reg_pkg::REG_CLUSTER_BOOT1:
            rdata_o = cluster_boot_addr_o[2*`SOC_DATA_W-1:`SOC_DATA_W];
         default:
            rdata_o = '0;
      endcase
   end

endmodule

`default_nettype wire

//--- design/fc_boot_regs.sv
/* Fabric controller boot registers */

`default_nettype none

`include "soc_ctrl_defines.svh"

module fc_boot_regs
(
   input  logic                        HCLK,
   input  logic                        HRESETn,
   input  soc_ctrl_sig_pkg::reg_wr_t   wr_i,
   input  soc_ctrl_sig_pkg::reg_rd_t   rd_i,
   input  soc_ctrl_sig_pkg::fc_side_t  side_i,
   output logic [`SOC_DATA_W-1:0]      fc_bootaddr_o,
   output logic                        fc_fetchen_o,
   output logic [`SOC_DATA_W-1:0]      rdata_o
);

   logic [`SOC_DATA_W-1:0] corestatus_q; // EOC in bit 31, status below
   logic                   bootsel_q;

   always_ff @(posedge HCLK or negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         fc_bootaddr_o <= `SOC_FC_BOOT_RST;
         fc_fetchen_o  <= 1'b0; // fc stays idle
         corestatus_q  <= '0;
      end
      else
      begin
         if (wr_i.we && wr_i.reg_id == soc_ctrl_reg_pkg::REG_FCBOOT)
            fc_bootaddr_o <= wr_i.wdata;
         if (wr_i.we && wr_i.reg_id == soc_ctrl_reg_pkg::REG_FCFETCH)
            fc_fetchen_o <= wr_i.wdata[0]; // APB beats the strobe
         else if (side_i.fetch_en_valid)
            fc_fetchen_o <= side_i.fetch_en;
         if (wr_i.we && wr_i.reg_id == soc_ctrl_reg_pkg::REG_CORESTATUS)
            corestatus_q <= wr_i.wdata;
      end
   end

   // boot select sampled during reset, frozen afterwards
   always_ff @(posedge HCLK or negedge HRESETn)
   begin
      if (!HRESETn)
         bootsel_q <= side_i.bootsel;
      else
         bootsel_q <= bootsel_q;
   end

   always_comb
   begin
      case (rd_i.reg_id)
         soc_ctrl_reg_pkg::REG_FCBOOT:     rdata_o = fc_bootaddr_o;
         soc_ctrl_reg_pkg::REG_FCFETCH:    rdata_o = {31'h0, fc_fetchen_o};
         soc_ctrl_reg_pkg::REG_CORESTATUS: rdata_o = corestatus_q;
         soc_ctrl_reg_pkg::REG_CS_RO:      rdata_o = corestatus_q;
         soc_ctrl_reg_pkg::REG_BOOTSEL:    rdata_o = {31'h0, bootsel_q};
         soc_ctrl_reg_pkg::REG_CLKSEL:     rdata_o = {31'h0, side_i.clksel}; // live level
         default:                          rdata_o = '0;
      endcase
   end

endmodule

`default_nettype wire

//--- design/jtag_mailbox.sv
/* JTAG mailbox */

`default_nettype none

`include "soc_ctrl_defines.svh"

module jtag_mailbox
(
   input  logic                        HCLK,
   input  logic                        HRESETn,
   input  soc_ctrl_sig_pkg::reg_wr_t   wr_i,
   input  soc_ctrl_sig_pkg::reg_rd_t   rd_i,
   input  logic [`SOC_JTAG_W-1:0]      jtag_reg_i,
   output logic [`SOC_JTAG_W-1:0]      jtag_reg_o,
   output logic [`SOC_DATA_W-1:0]      rdata_o
);

   logic [`SOC_JTAG_W-1:0] sync_q1; // first stage, may go metastable
   logic [`SOC_JTAG_W-1:0] sync_q2;

   always_ff @(posedge HCLK or negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         jtag_reg_o <= '0;
         sync_q1    <= '0;
         sync_q2    <= '0;
      end
      else
      begin
         sync_q1 <= jtag_reg_i;
         sync_q2 <= sync_q1;
         if (wr_i.we && wr_i.reg_id == soc_ctrl_reg_pkg::REG_JTAGREG)
            jtag_reg_o <= wr_i.wdata[`SOC_JTAG_W-1:0];
      end
   end

   // input side in 15:8, output side in 7:0
   assign rdata_o = (rd_i.reg_id == soc_ctrl_reg_pkg::REG_JTAGREG) ?
                    {16'h0, sync_q2, jtag_reg_o} : '0;

endmodule

`default_nettype wire

//--- design/pad_ctrl_bank.sv
/* Pad mux and pad configuration */

`default_nettype none

`include "soc_ctrl_defines.svh"

module pad_ctrl_bank
(
   input  logic                                           HCLK,
   input  logic                                           HRESETn,
   input  soc_ctrl_sig_pkg::reg_wr_t                      wr_i,
   input  soc_ctrl_sig_pkg::reg_rd_t                      rd_i,
   output logic [`SOC_NB_PADS-1:0][`SOC_PADMUX_W-1:0]     pad_mux_o,
   output logic [`SOC_NB_PADS-1:0][`SOC_PADCFG_W-1:0]     pad_cfg_o,
   output logic [`SOC_DATA_W-1:0]                         rdata_o
);

   // 16 mux fields per PADFUN word, 4 config bytes per PADCFG word
   always_ff @(posedge HCLK or negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         pad_mux_o <= '0;
         pad_cfg_o <= '1; // all pad options on
      end
      else if (wr_i.we)
      begin
         for (int n = 0; n < 4; n++)
         begin
            if (wr_i.reg_id == soc_ctrl_reg_pkg::soc_reg_e'(soc_ctrl_reg_pkg::REG_PADFUN0 + n))
            begin
               for (int k = 0; k < 16; k++)
                  pad_mux_o[16*n+k] <= wr_i.wdata[2*k +: `SOC_PADMUX_W];
            end
         end
         for (int n = 0; n < 16; n++)
         begin
            if (wr_i.reg_id == soc_ctrl_reg_pkg::soc_reg_e'(soc_ctrl_reg_pkg::REG_PADCFG0 + n))
            begin
               for (int k = 0; k < 4; k++)
                  pad_cfg_o[4*n+k] <= wr_i.wdata[8*k +: `SOC_PADCFG_W]; // full field kept
            end
         end
      end
   end

   // read back in the write layout
   always_comb
   begin
      rdata_o = '0;
      for (int n = 0; n < 4; n++)
      begin
         if (rd_i.reg_id == soc_ctrl_reg_pkg::soc_reg_e'(soc_ctrl_reg_pkg::REG_PADFUN0 + n))
         begin
            for (int k = 0; k < 16; k++)
               rdata_o[2*k +: `SOC_PADMUX_W] = pad_mux_o[16*n+k];
         end
      end
      for (int n = 0; n < 16; n++)
      begin
         if (rd_i.reg_id == soc_ctrl_reg_pkg::soc_reg_e'(soc_ctrl_reg_pkg::REG_PADCFG0 + n))
         begin
            for (int k = 0; k < 4; k++)
               rdata_o[8*k +: `SOC_PADCFG_W] = pad_cfg_o[4*n+k]; // bits 7:6 stay zero
         end
      end
   end

endmodule

`default_nettype wire

//--- design/soc_ctrl_apb_decode.sv
/* APB decode and read merge */

`default_nettype none

`include "soc_ctrl_defines.svh"

module soc_ctrl_apb_decode
(
   input  logic                           HCLK,
   input  logic                           HRESETn,
   input  logic [`SOC_ADDR_W-1:0]         paddr_i,
   input  logic [`SOC_DATA_W-1:0]         pwdata_i,
   input  logic                           pwrite_i,
   input  logic                           psel_i,
   input  logic                           penable_i,
   input  logic [`SOC_DATA_W-1:0]         rdata_pad_i,
   input  logic [`SOC_DATA_W-1:0]         rdata_fc_i,
   input  logic [`SOC_DATA_W-1:0]         rdata_clu_i,
   input  logic [`SOC_DATA_W-1:0]         rdata_jtag_i,
   output soc_ctrl_sig_pkg::reg_wr_t      wr_o,
   output soc_ctrl_sig_pkg::reg_rd_t      rd_o,
   output logic [`SOC_DATA_W-1:0]         prdata_o,
   output logic                           pready_o,
   output logic                           pslverr_o
);

   soc_ctrl_reg_pkg::soc_reg_e   sel_reg;
   logic [`SOC_DATA_W-1:0]       info_rdata;

   // word index, nothing selected outside a transfer
   assign sel_reg = psel_i ? soc_ctrl_reg_pkg::to_soc_reg(paddr_i[8:2])
                           : soc_ctrl_reg_pkg::REG_NONE;

   assign wr_o.we     = psel_i & penable_i & pwrite_i; // access phase write
   assign wr_o.reg_id = sel_reg;
   assign wr_o.wdata  = pwdata_i;
   assign rd_o.reg_id = sel_reg;

   // info word, core count over cluster count
   assign info_rdata = (sel_reg == soc_ctrl_reg_pkg::REG_INFO) ?
                       {16'(`SOC_NB_CORES), 16'(`SOC_NB_CLUSTERS)} : '0;

   // banks return zero when not addressed
   assign prdata_o  = rdata_pad_i | rdata_fc_i | rdata_clu_i | rdata_jtag_i | info_rdata;
   assign pready_o  = 1'b1; // no wait states
   assign pslverr_o = 1'b0;

endmodule

`default_nettype wire

//--- design/soc_ctrl_defines.svh
/* SoC control widths and reset values */

`ifndef SOC_CTRL_DEFINES_SVH
`define SOC_CTRL_DEFINES_SVH

// APB slave port
`define SOC_DATA_W        32
`define SOC_ADDR_W        12 // 4KB window

// pad control
`define SOC_NB_PADS       64
`define SOC_PADMUX_W      2
`define SOC_PADCFG_W      6 // pull up, pull down, ST, slew, 2b drive

// JTAG mailbox
`define SOC_JTAG_W        8

// info word contents
`define SOC_NB_CORES      4
`define SOC_NB_CLUSTERS   0

// fabric controller boot vector after reset
`define SOC_FC_BOOT_RST   32'h1A00_0080

`endif

//--- design/soc_ctrl_reg_pkg.sv
/* SoC control register map */

`default_nettype none

package soc_ctrl_reg_pkg;

   // word index PADDR[8:2]
   typedef enum logic [6:0]
   {
      REG_INFO          = 7'd0,
      REG_FCBOOT        = 7'd1,
      REG_FCFETCH       = 7'd2,
      REG_PADFUN0       = 7'd4,
      REG_PADFUN1       = 7'd5,
      REG_PADFUN2       = 7'd6,
      REG_PADFUN3       = 7'd7,
      REG_PADCFG0 = 7'd8,  REG_PADCFG1 = 7'd9,  REG_PADCFG2 = 7'd10, REG_PADCFG3 = 7'd11,
      REG_PADCFG4 = 7'd12, REG_PADCFG5 = 7'd13, REG_PADCFG6 = 7'd14, REG_PADCFG7 = 7'd15,
      REG_PADCFG8 = 7'd16, REG_PADCFG9 = 7'd17, REG_PADCFG10 = 7'd18, REG_PADCFG11 = 7'd19,
      REG_PADCFG12 = 7'd20, REG_PADCFG13 = 7'd21, REG_PADCFG14 = 7'd22, REG_PADCFG15 = 7'd23,
      REG_CLUSTER_CTRL  = 7'd28,
      REG_JTAGREG       = 7'd29,
      REG_CLUSTER_IRQ   = 7'd31,
      REG_CLUSTER_BOOT0 = 7'd32,
      REG_CLUSTER_BOOT1 = 7'd33,
      REG_CORESTATUS    = 7'd40,
      REG_CS_RO         = 7'd48, // read only mirror of core status
      REG_BOOTSEL       = 7'd49,
      REG_CLKSEL        = 7'd50,
      REG_NONE          = 7'd127 // any unmapped index
   } soc_reg_e;

   function automatic soc_reg_e to_soc_reg(input logic [6:0] idx);
      soc_reg_e r;
      if (idx inside {[7'd0:7'd2], [7'd4:7'd23], 7'd28, 7'd29, [7'd31:7'd33], 7'd40,
                      [7'd48:7'd50]})
         r = soc_reg_e'(idx);
      else
         r = REG_NONE; // holes in the map
      return r;
   endfunction

endpackage

`default_nettype wire

//--- design/soc_ctrl_sig_pkg.sv
/* SoC control block interconnect types */

`default_nettype none

`include "soc_ctrl_defines.svh"

package soc_ctrl_sig_pkg;

   // write command from the decoder to every bank
   typedef struct packed
   {
      logic                         we;
      soc_ctrl_reg_pkg::soc_reg_e   reg_id;
      logic [`SOC_DATA_W-1:0]       wdata;
   } reg_wr_t;

   // read request, register identity only
   typedef struct packed
   {
      soc_ctrl_reg_pkg::soc_reg_e   reg_id;
   } reg_rd_t;

   // bit 0 byp up to bit 3 rstn, same as the register layout
   typedef struct packed
   {
      logic rstn;
      logic fetch_en;
      logic pow;
      logic byp;
   } cluster_ctrl_t;

   // side-band inputs to the fc boot bank
   typedef struct packed
   {
      logic fetch_en_valid;
      logic fetch_en;
      logic bootsel;
      logic clksel;
   } fc_side_t;

endpackage

`default_nettype wire

//--- design/soc_ctrl_top.sv
/* SoC control register block */

`default_nettype none

`include "soc_ctrl_defines.svh"

module soc_ctrl_top
(
   input  logic                                        HCLK,
   input  logic                                        HRESETn,
   input  logic [`SOC_ADDR_W-1:0]                      PADDR,
   input  logic [`SOC_DATA_W-1:0]                      PWDATA,
   input  logic                                        PWRITE,
   input  logic                                        PSEL,
   input  logic                                        PENABLE,
   output logic [`SOC_DATA_W-1:0]                      PRDATA,
   output logic                                        PREADY,
   output logic                                        PSLVERR,
   input  logic                                        sel_fll_clk_i,
   input  logic                                        bootsel_i,
   input  logic                                        fc_fetch_en_valid_i,
   input  logic                                        fc_fetch_en_i,
   input  logic [`SOC_JTAG_W-1:0]                      soc_jtag_reg_i,
   output logic [`SOC_NB_PADS-1:0][`SOC_PADCFG_W-1:0]  pad_cfg_o,
   output logic [`SOC_NB_PADS-1:0][`SOC_PADMUX_W-1:0]  pad_mux_o,
   output logic [`SOC_JTAG_W-1:0]                      soc_jtag_reg_o,
   output logic [`SOC_DATA_W-1:0]                      fc_bootaddr_o,
   output logic                                        fc_fetchen_o,
   output soc_ctrl_sig_pkg::cluster_ctrl_t             cluster_ctrl_o,
   output logic                                        cluster_irq_o,
   output logic [2*`SOC_DATA_W-1:0]                    cluster_boot_addr_o
);

   soc_ctrl_sig_pkg::reg_wr_t    wr;
   soc_ctrl_sig_pkg::reg_rd_t    rd;
   soc_ctrl_sig_pkg::fc_side_t   fc_side;
   logic [`SOC_DATA_W-1:0]       rdata_pad;
   logic [`SOC_DATA_W-1:0]       rdata_fc;
   logic [`SOC_DATA_W-1:0]       rdata_clu;
   logic [`SOC_DATA_W-1:0]       rdata_jtag;

   assign fc_side = '{fetch_en_valid: fc_fetch_en_valid_i, fetch_en: fc_fetch_en_i,
                      bootsel: bootsel_i, clksel: sel_fll_clk_i};

   soc_ctrl_apb_decode u_decode
   (
      .HCLK(HCLK), .HRESETn(HRESETn),
      .paddr_i(PADDR), .pwdata_i(PWDATA), .pwrite_i(PWRITE),
      .psel_i(PSEL), .penable_i(PENABLE),
      .rdata_pad_i(rdata_pad), .rdata_fc_i(rdata_fc),
      .rdata_clu_i(rdata_clu), .rdata_jtag_i(rdata_jtag),
      .wr_o(wr), .rd_o(rd),
      .prdata_o(PRDATA), .pready_o(PREADY), .pslverr_o(PSLVERR)
   );

   pad_ctrl_bank u_pad
   (
      .HCLK(HCLK), .HRESETn(HRESETn), .wr_i(wr), .rd_i(rd),
      .pad_mux_o(pad_mux_o), .pad_cfg_o(pad_cfg_o), .rdata_o(rdata_pad)
   );

   fc_boot_regs u_fc
   (
      .HCLK(HCLK), .HRESETn(HRESETn), .wr_i(wr), .rd_i(rd), .side_i(fc_side),
      .fc_bootaddr_o(fc_bootaddr_o), .fc_fetchen_o(fc_fetchen_o), .rdata_o(rdata_fc)
   );

   cluster_ctrl_regs u_clu
   (
      .HCLK(HCLK), .HRESETn(HRESETn), .wr_i(wr), .rd_i(rd),
      .cluster_ctrl_o(cluster_ctrl_o), .cluster_irq_o(cluster_irq_o),
      .cluster_boot_addr_o(cluster_boot_addr_o), .rdata_o(rdata_clu)
   );

   jtag_mailbox u_jtag
   (
      .HCLK(HCLK), .HRESETn(HRESETn), .wr_i(wr), .rd_i(rd),
      .jtag_reg_i(soc_jtag_reg_i), .jtag_reg_o(soc_jtag_reg_o), .rdata_o(rdata_jtag)
   );

endmodule

`default_nettype wire

//--- verification/soc_ctrl_sva.sv
/* SoC control bound assertions */

`default_nettype none

`include "soc_ctrl_defines.svh"

module soc_ctrl_sva
(
   input logic                    HCLK,
   input logic                    HRESETn,
   input logic [`SOC_ADDR_W-1:0]  paddr_i,
   input logic                    pwrite_i,
   input logic                    psel_i,
   input logic                    penable_i,
   input logic                    pready_i,
   input logic                    pslverr_i,
   input logic                    fetch_valid_i,
   input logic                    fetch_en_i,
   input logic                    fc_fetchen_i
);

   logic fetch_wr; // APB write to the fetch enable word

   assign fetch_wr = psel_i & penable_i & pwrite_i &
                     (paddr_i[8:2] == soc_ctrl_reg_pkg::REG_FCFETCH);

   a_no_wait_no_err: assert property (@(posedge HCLK) disable iff (!HRESETn)
      pready_i && !pslverr_i)
      else $error("PREADY low or PSLVERR high outside reset");

   a_fetch_reset: assert property (@(posedge HCLK) $rose(HRESETn) |-> !fc_fetchen_i)
      else $error("fetch enable not cleared by reset");

   // a strobe without a competing APB write loads the level
   a_fetch_strobe: assert property (@(posedge HCLK) disable iff (!HRESETn)
      fetch_valid_i && !fetch_wr |=> fc_fetchen_i == $past(fetch_en_i))
      else $error("side-band strobe did not load the fetch enable");

endmodule

bind soc_ctrl_top soc_ctrl_sva u_sva
(
   .HCLK(HCLK), .HRESETn(HRESETn), .paddr_i(PADDR), .pwrite_i(PWRITE),
   .psel_i(PSEL), .penable_i(PENABLE), .pready_i(PREADY), .pslverr_i(PSLVERR),
   .fetch_valid_i(fc_fetch_en_valid_i), .fetch_en_i(fc_fetch_en_i),
   .fc_fetchen_i(fc_fetchen_o)
);

`default_nettype wire

//--- verification/soc_ctrl_tb.sv
/* SoC control testbench */

`default_nettype none

`include "soc_ctrl_defines.svh"

module soc_ctrl_tb;

   localparam int NB_ITER     = 200; // one write and one read each
   localparam int PLAN_CYCLES = 4 + 6 * 32 + 11 * NB_ITER;
   localparam int CYCLE_LIMIT = 2 * PLAN_CYCLES;

   typedef logic [383:0] chk_w_t; // widest compared value is the pad config bus

   logic                                        HCLK;
   logic                                        HRESETn;
   logic [`SOC_ADDR_W-1:0]                      PADDR;
   logic [`SOC_DATA_W-1:0]                      PWDATA;
   logic                                        PWRITE;
   logic                                        PSEL;
   logic                                        PENABLE;
   logic [`SOC_DATA_W-1:0]                      PRDATA;
   logic                                        PREADY;
   logic                                        PSLVERR;
   logic                                        sel_fll_clk_i;
   logic                                        bootsel_i;
   logic                                        fc_fetch_en_valid_i;
   logic                                        fc_fetch_en_i;
   logic [`SOC_JTAG_W-1:0]                      soc_jtag_reg_i;
   logic [`SOC_NB_PADS-1:0][`SOC_PADCFG_W-1:0]  pad_cfg_o;
   logic [`SOC_NB_PADS-1:0][`SOC_PADMUX_W-1:0]  pad_mux_o;
   logic [`SOC_JTAG_W-1:0]                      soc_jtag_reg_o;
   logic [`SOC_DATA_W-1:0]                      fc_bootaddr_o;
   logic                                        fc_fetchen_o;
   soc_ctrl_sig_pkg::cluster_ctrl_t             cluster_ctrl_o;
   logic                                        cluster_irq_o;
   logic [2*`SOC_DATA_W-1:0]                    cluster_boot_addr_o;

   // reference copy of every kept register
   logic [`SOC_NB_PADS-1:0][`SOC_PADMUX_W-1:0]  m_mux;
   logic [`SOC_NB_PADS-1:0][`SOC_PADCFG_W-1:0]  m_cfg;
   logic [`SOC_DATA_W-1:0]                      m_fcboot;
   logic [`SOC_DATA_W-1:0]                      m_core;
   logic                                        m_fetch;
   logic                                        m_bootsel; // level seen during reset
   soc_ctrl_sig_pkg::cluster_ctrl_t             m_clu;
   logic                                        m_irq;
   logic [2*`SOC_DATA_W-1:0]                    m_cboot;
   logic [`SOC_JTAG_W-1:0]                      m_jout;
   logic [`SOC_JTAG_W-1:0]                      m_jin; // settled JTAG input
   logic                                        strobe_req;
   logic                                        strobe_val;
   logic [31:0]                                 lcg_state = 32'd30010;
   int                                          cycles = 0;

   soc_ctrl_top uut
   (
      .HCLK(HCLK), .HRESETn(HRESETn),
      .PADDR(PADDR), .PWDATA(PWDATA), .PWRITE(PWRITE), .PSEL(PSEL), .PENABLE(PENABLE),
      .PRDATA(PRDATA), .PREADY(PREADY), .PSLVERR(PSLVERR),
      .sel_fll_clk_i(sel_fll_clk_i), .bootsel_i(bootsel_i),
      .fc_fetch_en_valid_i(fc_fetch_en_valid_i), .fc_fetch_en_i(fc_fetch_en_i),
      .soc_jtag_reg_i(soc_jtag_reg_i),
      .pad_cfg_o(pad_cfg_o), .pad_mux_o(pad_mux_o), .soc_jtag_reg_o(soc_jtag_reg_o),
      .fc_bootaddr_o(fc_bootaddr_o), .fc_fetchen_o(fc_fetchen_o),
      .cluster_ctrl_o(cluster_ctrl_o), .cluster_irq_o(cluster_irq_o),
      .cluster_boot_addr_o(cluster_boot_addr_o)
   );

   always #10 HCLK = ~HCLK;

   always @(posedge HCLK)
   begin
      cycles = cycles + 1;
      if (cycles > CYCLE_LIMIT)
      begin
         $display("Regression failed");
         $fatal(1, "simulation did not finish within %0d cycles", CYCLE_LIMIT);
      end
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   function automatic logic [`SOC_ADDR_W-1:0] word_addr(input logic [6:0] idx);
      return {3'b000, idx, 2'b00};
   endfunction

   // n-th of the 32 mapped word indices
   function automatic logic [6:0] mapped_index(input logic [4:0] n);
      if (n < 5'd3)
         return {2'b00, n};
      if (n < 5'd23)
         return {2'b00, n} + 7'd1; // pad words 4..23
      case (n)
         5'd23:   return soc_ctrl_reg_pkg::REG_CLUSTER_CTRL;
         5'd24:   return soc_ctrl_reg_pkg::REG_JTAGREG;
         5'd25:   return soc_ctrl_reg_pkg::REG_CLUSTER_IRQ;
         5'd26:   return soc_ctrl_reg_pkg::REG_CLUSTER_BOOT0;
         5'd27:   return soc_ctrl_reg_pkg::REG_CLUSTER_BOOT1;
         5'd28:   return soc_ctrl_reg_pkg::REG_CORESTATUS;
         5'd29:   return soc_ctrl_reg_pkg::REG_CS_RO;
         5'd30:   return soc_ctrl_reg_pkg::REG_BOOTSEL;
         default: return soc_ctrl_reg_pkg::REG_CLKSEL;
      endcase
   endfunction

   // mostly mapped words, now and then any 7-bit index
   function automatic logic [6:0] pick_index(input logic [31:0] r);
      return (r[31:28] == 4'd0) ? r[22:16] : mapped_index(r[27:23]);
   endfunction

   function automatic void model_reset(input logic bootsel);
      m_mux     = '0;
      m_cfg     = '1;
      m_fcboot  = `SOC_FC_BOOT_RST;
      m_core    = '0;
      m_fetch   = 1'b0;
      m_bootsel = bootsel;
      m_clu     = '{rstn: 1'b1, fetch_en: 1'b0, pow: 1'b0, byp: 1'b1};
      m_irq     = 1'b0;
      m_cboot   = '0;
      m_jout    = '0;
      m_jin     = '0;
   endfunction

   function automatic void model_write(input logic [6:0] idx, input logic [31:0] d);
      int base;
      if (idx >= 7'd4 && idx <= 7'd7)
      begin
         base = 16 * (int'(idx) - 4);
         for (int k = 0; k < 16; k++)
            m_mux[base + k] = d[2*k +: 2];
      end
      else if (idx >= 7'd8 && idx <= 7'd23)
      begin
         base = 4 * (int'(idx) - 8);
         for (int k = 0; k < 4; k++)
            m_cfg[base + k] = d[8*k +: 6];
      end
      else
      begin
         case (idx)
            soc_ctrl_reg_pkg::REG_FCBOOT:        m_fcboot = d;
            soc_ctrl_reg_pkg::REG_FCFETCH:       m_fetch = d[0];
            soc_ctrl_reg_pkg::REG_CLUSTER_CTRL:  m_clu = soc_ctrl_sig_pkg::cluster_ctrl_t'(d[3:0]);
            soc_ctrl_reg_pkg::REG_JTAGREG:       m_jout = d[7:0];
            soc_ctrl_reg_pkg::REG_CLUSTER_IRQ:   m_irq = d[0];
            soc_ctrl_reg_pkg::REG_CLUSTER_BOOT0: m_cboot[31:0] = d;
            soc_ctrl_reg_pkg::REG_CLUSTER_BOOT1: m_cboot[63:32] = d;
            soc_ctrl_reg_pkg::REG_CORESTATUS:    m_core = d;
            default:                             ; // read only or unmapped
         endcase
      end
   endfunction

   function automatic logic [31:0] model_read(input logic [6:0] idx);
      logic [31:0] v;
      int          base;
      v = '0;
      if (idx >= 7'd4 && idx <= 7'd7)
      begin
         base = 16 * (int'(idx) - 4);
         for (int k = 0; k < 16; k++)
            v[2*k +: 2] = m_mux[base + k];
      end
      else if (idx >= 7'd8 && idx <= 7'd23)
      begin
         base = 4 * (int'(idx) - 8);
         for (int k = 0; k < 4; k++)
            v[8*k +: 6] = m_cfg[base + k];
      end
      else
      begin
         case (idx)
            soc_ctrl_reg_pkg::REG_INFO:          v = {16'(`SOC_NB_CORES), 16'(`SOC_NB_CLUSTERS)};
            soc_ctrl_reg_pkg::REG_FCBOOT:        v = m_fcboot;
            soc_ctrl_reg_pkg::REG_FCFETCH:       v = {31'h0, m_fetch};
            soc_ctrl_reg_pkg::REG_CLUSTER_CTRL:  v = {28'h0, m_clu};
            soc_ctrl_reg_pkg::REG_JTAGREG:       v = {16'h0, m_jin, m_jout};
            soc_ctrl_reg_pkg::REG_CLUSTER_IRQ:   v = {31'h0, m_irq};
            soc_ctrl_reg_pkg::REG_CLUSTER_BOOT0: v = m_cboot[31:0];
            soc_ctrl_reg_pkg::REG_CLUSTER_BOOT1: v = m_cboot[63:32];
            soc_ctrl_reg_pkg::REG_CORESTATUS:    v = m_core;
            soc_ctrl_reg_pkg::REG_CS_RO:         v = m_core; // mirror
            soc_ctrl_reg_pkg::REG_BOOTSEL:       v = {31'h0, m_bootsel};
            soc_ctrl_reg_pkg::REG_CLKSEL:        v = {31'h0, sel_fll_clk_i};
            default:                             v = '0;
         endcase
      end
      return v;
   endfunction

   task automatic check_val(input string name, input chk_w_t exp, input chk_w_t act);
      assert (exp === act)
      else
      begin
         $display("[ERROR] %s expected %0h actual %0h", name, exp, act);
         $display("Regression failed");
         $fatal(1, "value mismatch on %s", name);
      end
   endtask

   task automatic check_outputs();
      check_val("pad_mux_o", chk_w_t'(m_mux), chk_w_t'(pad_mux_o));
      check_val("pad_cfg_o", chk_w_t'(m_cfg), chk_w_t'(pad_cfg_o));
      check_val("soc_jtag_reg_o", chk_w_t'(m_jout), chk_w_t'(soc_jtag_reg_o));
      check_val("fc_bootaddr_o", chk_w_t'(m_fcboot), chk_w_t'(fc_bootaddr_o));
      check_val("fc_fetchen_o", chk_w_t'(m_fetch), chk_w_t'(fc_fetchen_o));
      check_val("cluster_ctrl_o", chk_w_t'(m_clu), chk_w_t'(cluster_ctrl_o));
      check_val("cluster_irq_o", chk_w_t'(m_irq), chk_w_t'(cluster_irq_o));
      check_val("cluster_boot_addr_o", chk_w_t'(m_cboot), chk_w_t'(cluster_boot_addr_o));
   endtask

   task automatic next_cycle();
      @(posedge HCLK);
      #1;
   endtask

   task automatic wait_ready();
      @(negedge HCLK);
      while (!PREADY)
         @(negedge HCLK);
   endtask

   task automatic bus_idle();
      PSEL                = 1'b0;
      PENABLE             = 1'b0;
      PWRITE              = 1'b0;
      fc_fetch_en_valid_i = 1'b0;
   endtask

   task automatic apb_write(input logic [6:0] idx, input logic [31:0] data);
      next_cycle();
      PADDR   = word_addr(idx);
      PWDATA  = data;
      PWRITE  = 1'b1;
      PSEL    = 1'b1;
      PENABLE = 1'b0;
      next_cycle();
      PENABLE             = 1'b1;
      fc_fetch_en_valid_i = strobe_req; // optional strobe in the access phase
      fc_fetch_en_i       = strobe_val;
      wait_ready();
      next_cycle();
      bus_idle();
      model_write(idx, data);
      if (strobe_req && idx != soc_ctrl_reg_pkg::REG_FCFETCH)
         m_fetch = strobe_val; // APB write to the fetch word wins
      strobe_req = 1'b0;
      @(negedge HCLK);
      check_outputs();
   endtask

   task automatic apb_read_check(input logic [6:0] idx);
      next_cycle();
      PADDR   = word_addr(idx);
      PWRITE  = 1'b0;
      PSEL    = 1'b1;
      PENABLE = 1'b0;
      next_cycle();
      PENABLE = 1'b1;
      wait_ready();
      check_val($sformatf("PRDATA word %0d", idx), chk_w_t'(model_read(idx)), chk_w_t'(PRDATA));
      next_cycle();
      bus_idle();
   endtask

   task automatic fetch_strobe(input logic val);
      next_cycle();
      fc_fetch_en_valid_i = 1'b1;
      fc_fetch_en_i       = val;
      next_cycle();
      fc_fetch_en_valid_i = 1'b0;
      m_fetch             = val;
      @(negedge HCLK);
      check_val("fc_fetchen_o", chk_w_t'(m_fetch), chk_w_t'(fc_fetchen_o));
   endtask

   // new input level must reach read data on the third cycle, not before
   task automatic jtag_latency_check(input logic [`SOC_JTAG_W-1:0] val);
      logic [`SOC_JTAG_W-1:0] old;
      old = m_jin;
      next_cycle();
      soc_jtag_reg_i = val;
      PADDR          = word_addr(soc_ctrl_reg_pkg::REG_JTAGREG);
      PWRITE         = 1'b0;
      PSEL           = 1'b1;
      PENABLE        = 1'b0;
      @(negedge HCLK);
      check_val("PRDATA[15:8] cycle 0", chk_w_t'(old), chk_w_t'(PRDATA[15:8]));
      next_cycle();
      PENABLE = 1'b1;
      @(negedge HCLK);
      check_val("PRDATA[15:8] cycle 1", chk_w_t'(old), chk_w_t'(PRDATA[15:8]));
      next_cycle();
      PENABLE = 1'b0; // back-to-back read
      @(negedge HCLK);
      check_val("PRDATA[15:8] cycle 2", chk_w_t'(val), chk_w_t'(PRDATA[15:8]));
      next_cycle();
      PENABLE = 1'b1;
      next_cycle();
      bus_idle();
      m_jin = val;
   endtask

   task automatic set_levels(input logic clksel, input logic bootsel);
      next_cycle();
      sel_fll_clk_i = clksel;
      bootsel_i     = bootsel; // no effect once out of reset
   endtask

   initial
   begin
      logic [31:0] r;
      logic [6:0]  idx;
      logic [6:0]  ridx;
      HCLK                = 1'b0;
      HRESETn             = 1'b0;
      PADDR               = '0;
      PWDATA              = '0;
      PWRITE              = 1'b0;
      PSEL                = 1'b0;
      PENABLE             = 1'b0;
      sel_fll_clk_i       = 1'b0;
      fc_fetch_en_valid_i = 1'b0;
      fc_fetch_en_i       = 1'b0;
      soc_jtag_reg_i      = '0;
      strobe_req          = 1'b0;
      strobe_val          = 1'b0;
      r                   = lcg_next();
      bootsel_i           = r[25];
      model_reset(r[25]);
      repeat (4) @(posedge HCLK);
      #1;
      HRESETn = 1'b1;
      @(negedge HCLK);
      check_outputs();
      for (int n = 0; n < 32; n++)
         apb_read_check(mapped_index(5'(n)));
      for (int i = 0; i < NB_ITER; i++)
      begin
         r          = lcg_next();
         idx        = pick_index(r);
         strobe_req = (r[15:13] == 3'd0);
         strobe_val = r[12];
         if (strobe_req && r[11])
            idx = soc_ctrl_reg_pkg::REG_FCFETCH; // force the override case
         apb_write(idx, lcg_next());
         r    = lcg_next();
         ridx = r[15] ? idx : pick_index(r);
         apb_read_check(ridx);
         case (r[14:12])
            3'd0:    fetch_strobe(r[11]);
            3'd1:    jtag_latency_check(r[24:17]);
            3'd2:    set_levels(r[26], r[27]);
            default: ;
         endcase
      end
      for (int n = 0; n < 32; n++)
         apb_read_check(mapped_index(5'(n)));
      $display("Regression passed");
      $finish;
   end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+design
design/soc_ctrl_reg_pkg.sv
design/soc_ctrl_sig_pkg.sv
design/soc_ctrl_apb_decode.sv
design/pad_ctrl_bank.sv
design/fc_boot_regs.sv
design/cluster_ctrl_regs.sv
design/jtag_mailbox.sv
design/soc_ctrl_top.sv
verification/soc_ctrl_sva.sv
verification/soc_ctrl_tb.sv
